// File: common/bus_pkg.sv
// Write bus definitions for the enable generator
// Address and data types, register offsets and the write FSM states
package bus_pkg;

    // Bus address and write data
    typedef logic [31:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;

    // Register offsets from the block base address
    localparam bus_addr_t REG_RUN       = 32'h0000_0000;
    localparam bus_addr_t REG_PERIOD    = 32'h0000_0004;
    localparam bus_addr_t REG_THRESHOLD = 32'h0000_0008;

    // Write FSM states
    // Idle waits for a strobe, apply commits the latched write
    typedef enum logic {
        BUS_IDLE,
        BUS_APPLY
    } bus_state_t;

endpackage

// File: common/timebase_pkg.sv
// Timebase definitions for the enable generator
// Enable level type, default count width and the bypass period limit
package timebase_pkg;

    // Single bit enable and timebase level
    typedef logic enable_t;

    // Default width of the period counter and its registers
    localparam int unsigned DEFAULT_COUNTER_WIDTH = 32;

    // Periods at or below this pass the external timebase through
    localparam int unsigned BYPASS_PERIOD_MAX = 1;

endpackage

// File: hdl/bus_register_file.sv
// Bus register file
// Takes writes on the simple write bus and holds the run bit,
// the period and the threshold of the enable generator
module bus_register_file
    import bus_pkg::*;
    import timebase_pkg::*;
#(
    parameter bus_addr_t   BASE_ADDRESS  = '0,
    parameter int unsigned COUNTER_WIDTH = DEFAULT_COUNTER_WIDTH
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     write_strobe,
    input  bus_addr_t                address,
    input  bus_data_t                write_data,
    output logic                     ready,
    output enable_t                  run,
    output logic [COUNTER_WIDTH-1:0] period,
    output logic [COUNTER_WIDTH-1:0] threshold
);

    bus_state_t state;
    bus_addr_t  latched_offset;
    bus_data_t  latched_data;
    logic       write_accept;

    // Strobes only count while idle and ready
    assign write_accept = write_strobe && ready && (state == BUS_IDLE);

    // Shadow copy of the accepted write
    always_ff @(posedge clock) begin
        if (write_accept) begin
            latched_offset <= address - BASE_ADDRESS;
            latched_data   <= write_data;
        end
    end

    // Write FSM
    // Ready stays low through apply and the first idle cycle after it
    always_ff @(posedge clock) begin
        if (!reset) begin
            state     <= BUS_IDLE;
            ready     <= 1'b1;
            run       <= 1'b0;
            period    <= '0;
            threshold <= '0;
        end else begin
            case (state)
                BUS_IDLE: begin
                    if (write_accept) begin
                        state <= BUS_APPLY;
                        ready <= 1'b0;
                    end else begin
                        ready <= 1'b1;
                    end
                end
                BUS_APPLY: begin
                    case (latched_offset)
                        REG_RUN: begin
                            run <= latched_data[0];
                        end
                        REG_PERIOD: begin
                            period <= COUNTER_WIDTH'(latched_data);
                        end
                        REG_THRESHOLD: begin
                            threshold <= COUNTER_WIDTH'(latched_data);
                        end
                        default: begin
                            // Writes to unmapped offsets are dropped
                        end
                    endcase
                    state <= BUS_IDLE;
                end
            endcase
        end
    end

endmodule

// File: timebase/period_counter.sv
// Period counter
// Counts from zero to period minus one and wraps while enabled,
// and is held at zero whenever it is disabled
module period_counter
    import timebase_pkg::*;
#(
    parameter int unsigned COUNTER_WIDTH = DEFAULT_COUNTER_WIDTH
) (
    input  logic                     clock,
    input  logic                     reset,
    input  enable_t                  counter_enable,
    input  logic [COUNTER_WIDTH-1:0] period,
    output logic [COUNTER_WIDTH-1:0] count
);

    // One extra bit so the increment never overflows
    logic [COUNTER_WIDTH:0] count_next;
    logic                   wrap;

    assign count_next = {1'b0, count} + (COUNTER_WIDTH + 1)'(1);

    // Also catches a period that was lowered below the current count
    assign wrap = (count_next >= {1'b0, period});

    always_ff @(posedge clock) begin
        if (!reset) begin
            count <= '0;
        end else if (!counter_enable) begin
            // Stopped, so every run starts at the same phase
            count <= '0;
        end else if (wrap) begin
            count <= '0;
        end else begin
            count <= count_next[COUNTER_WIDTH-1:0];
        end
    end

endmodule

// File: timebase/enable_pulse_shaper.sv
// Enable pulse shaper
// One cycle pulse on the rising edge of the registered threshold match,
// or the registered external timebase for periods of 0 and 1
module enable_pulse_shaper
    import timebase_pkg::*;
#(
    parameter int unsigned COUNTER_WIDTH = DEFAULT_COUNTER_WIDTH
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic [COUNTER_WIDTH-1:0] count,
    input  logic [COUNTER_WIDTH-1:0] period,
    input  logic [COUNTER_WIDTH-1:0] threshold,
    input  enable_t                  ext_timebase,
    output enable_t                  enable_out
);

    enable_t match;
    enable_t match_prev;
    enable_t match_rise;
    logic    bypass;

    assign match_rise = match && !match_prev;
    assign bypass     = (period <= BYPASS_PERIOD_MAX);

    always_ff @(posedge clock) begin
        if (!reset) begin
            match      <= 1'b0;
            match_prev <= 1'b0;
            enable_out <= 1'b0;
        end else begin
            match      <= (count == threshold);
            match_prev <= match;
            // Short periods take the external timebase instead
            if (bypass) begin
                enable_out <= ext_timebase;
            end else begin
                enable_out <= match_rise;
            end
        end
    end

endmodule

// File: hdl/enable_generator.sv
// Programmable enable generator
// Bus register file, period counter and pulse shaper; the counter
// runs from the run bit or the gen_enable_in pin
module enable_generator
    import bus_pkg::*;
    import timebase_pkg::*;
#(
    parameter bus_addr_t   BASE_ADDRESS  = '0,
    parameter int unsigned COUNTER_WIDTH = DEFAULT_COUNTER_WIDTH
) (
    input  logic      clock,
    input  logic      reset,
    input  logic      write_strobe,
    input  bus_addr_t address,
    input  bus_data_t write_data,
    output logic      ready,
    input  enable_t   gen_enable_in,
    input  enable_t   ext_timebase,
    output enable_t   enable_out
);

    enable_t                  run;
    enable_t                  counter_enable;
    logic [COUNTER_WIDTH-1:0] period;
    logic [COUNTER_WIDTH-1:0] threshold;
    logic [COUNTER_WIDTH-1:0] count;

    // Either run source starts the counter
    assign counter_enable = run || gen_enable_in;

    bus_register_file #(
        .BASE_ADDRESS  (BASE_ADDRESS),
        .COUNTER_WIDTH (COUNTER_WIDTH)
    ) i_bus_register_file (
        .clock        (clock),
        .reset        (reset),
        .write_strobe (write_strobe),
        .address      (address),
        .write_data   (write_data),
        .ready        (ready),
        .run          (run),
        .period       (period),
        .threshold    (threshold)
    );

    period_counter #(
        .COUNTER_WIDTH (COUNTER_WIDTH)
    ) i_period_counter (
        .clock          (clock),
        .reset          (reset),
        .counter_enable (counter_enable),
        .period         (period),
        .count          (count)
    );

    enable_pulse_shaper #(
        .COUNTER_WIDTH (COUNTER_WIDTH)
    ) i_enable_pulse_shaper (
        .clock        (clock),
        .reset        (reset),
        .count        (count),
        .period       (period),
        .threshold    (threshold),
        .ext_timebase (ext_timebase),
        .enable_out   (enable_out)
    );

endmodule

// File: verification/tb_enable_generator.sv
// Testbench for the enable generator
// Reads test cases from a text file, sets up the DUT over the write bus
// and checks pulse count, pulse spacing and the external timebase bypass
module tb_enable_generator
    import bus_pkg::*;
    import timebase_pkg::*;
();

    localparam bus_addr_t BASE_ADDRESS = 32'h0000_4000;
    // Offset that maps to no register
    localparam bus_addr_t REG_UNMAPPED = 32'h0000_000C;

    logic      clock;
    logic      reset;
    logic      write_strobe;
    bus_addr_t address;
    bus_data_t write_data;
    logic      ready;
    enable_t   gen_enable_in;
    enable_t   ext_timebase;
    enable_t   enable_out;

    string case_names[$];
    string case_sources[$];
    int    case_periods[$];
    int    case_thresholds[$];
    int    case_cycles[$];
    int    case_pulses[$];
    int    case_spacings[$];
    int    error_count;
    int    watchdog_cycles = 0;

    enable_generator #(
        .BASE_ADDRESS  (BASE_ADDRESS),
        .COUNTER_WIDTH (32)
    ) i_enable_generator (
        .clock         (clock),
        .reset         (reset),
        .write_strobe  (write_strobe),
        .address       (address),
        .write_data    (write_data),
        .ready         (ready),
        .gen_enable_in (gen_enable_in),
        .ext_timebase  (ext_timebase),
        .enable_out    (enable_out)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // Random external timebase with one new bit per cycle
    initial begin
        logic [31:0] random_word;
        random_word = $urandom(15);
        ext_timebase = 1'b0;
        forever begin
            @(posedge clock);
            #1;
            random_word = $urandom();
            ext_timebase = random_word[0];
        end
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clock);
        $display("Watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
        $display("STATUS: FAIL");
        $finish;
    end

    // Pulse count and spacing as the period rules give them
    function automatic int expected_pulses(input int period, input int threshold,
                                           input string source, input int cycles);
        if (period <= BYPASS_PERIOD_MAX || source == "none" || threshold >= period) begin
            return 0;
        end
        return cycles / period;
    endfunction

    function automatic int expected_spacing(input int period, input int threshold,
                                            input string source);
        if (period <= BYPASS_PERIOD_MAX || source == "none" || threshold >= period) begin
            return 0;
        end
        return period;
    endfunction

    task automatic load_cases();
        int    fd;
        string line;
        string name;
        string source;
        int    fields[5];
        fd = $fopen("verification/enable_cases.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("Could not open the case file verification/enable_cases.txt");
            return;
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) > 0) begin
                // Comment and blank lines do not give seven fields
                if ($sscanf(line, "%s %d %d %s %d %d %d", name, fields[0], fields[1], source,
                            fields[2], fields[3], fields[4]) == 7) begin
                    if (source != "bus" && source != "pin" && source != "none") begin
                        error_count++;
                        $display("Case %s has an unknown run source %s", name, source);
                    end else begin
                        case_names.push_back(name);
                        case_sources.push_back(source);
                        case_periods.push_back(fields[0]);
                        case_thresholds.push_back(fields[1]);
                        case_cycles.push_back(fields[2]);
                        case_pulses.push_back(fields[3]);
                        case_spacings.push_back(fields[4]);
                    end
                end
            end
        end
        $fclose(fd);
    endtask

    // One write; optionally keeps a conflicting strobe up while busy
    task automatic bus_write(input bus_addr_t offset, input bus_data_t data,
                             input logic busy_strobe, input string name);
        int busy_cycles;
        while (!ready) begin
            @(posedge clock);
            #1;
        end
        write_strobe = 1'b1;
        address = BASE_ADDRESS + offset;
        write_data = data;
        @(posedge clock);
        #1;
        if (busy_strobe) begin
            address = BASE_ADDRESS + REG_PERIOD;
            write_data = ~data;
        end else begin
            write_strobe = 1'b0;
        end
        busy_cycles = 0;
        while (!ready && busy_cycles < 4) begin
            busy_cycles++;
            @(posedge clock);
            #1;
        end
        write_strobe = 1'b0;
        assert (busy_cycles == 2) else begin
            error_count++;
            $display("[FAIL] %s ready low cycles: expected %0d actual %0d", name, 2, busy_cycles);
        end
    endtask

    // Samples at the falling edge away from the DUT updates
    task automatic observe_window(input string name, input int period, input int cycles,
                                  input int exp_pulses, input int exp_spacing);
        int   pulses;
        int   last_pulse;
        int   cycle;
        logic prev_out;
        logic prev_ext;
        pulses = 0;
        last_pulse = -1;
        @(negedge clock);
        prev_out = enable_out;
        prev_ext = ext_timebase;
        for (cycle = 0; cycle < cycles; cycle++) begin
            @(negedge clock);
            if (period <= BYPASS_PERIOD_MAX) begin
                assert (enable_out == prev_ext) else begin
                    error_count++;
                    $display("[FAIL] %s bypass cycle %0d: expected %0b actual %0b",
                             name, cycle, prev_ext, enable_out);
                end
            end else if (enable_out) begin
                assert (!prev_out) else begin
                    error_count++;
                    $display("[FAIL] %s pulse width at cycle %0d: expected %0b actual %0b",
                             name, cycle, 1'b0, enable_out);
                end
                if (last_pulse >= 0) begin
                    assert (cycle - last_pulse == exp_spacing) else begin
                        error_count++;
                        $display("[FAIL] %s pulse spacing: expected %0d actual %0d",
                                 name, exp_spacing, cycle - last_pulse);
                    end
                end
                last_pulse = cycle;
                pulses++;
            end
            prev_out = enable_out;
            prev_ext = ext_timebase;
        end
        if (period > BYPASS_PERIOD_MAX) begin
            assert (pulses == exp_pulses) else begin
                error_count++;
                $display("[FAIL] %s pulse count: expected %0d actual %0d",
                         name, exp_pulses, pulses);
            end
        end
    endtask

    task automatic run_case(input int index);
        string name;
        string source;
        int    period;
        int    threshold;
        int    exp_pulses;
        int    exp_spacing;
        name = case_names[index];
        source = case_sources[index];
        period = case_periods[index];
        threshold = case_thresholds[index];
        exp_pulses = expected_pulses(period, threshold, source, case_cycles[index]);
        exp_spacing = expected_spacing(period, threshold, source);
        assert (exp_pulses == case_pulses[index] && exp_spacing == case_spacings[index])
        else begin
            error_count++;
            $display("Case %s: the expected values in the case file break the period rules",
                     name);
        end
        // Stop first so the counter starts from zero
        gen_enable_in = 1'b0;
        bus_write(REG_RUN, '0, 1'b0, name);
        bus_write(REG_PERIOD, bus_data_t'(period), 1'b0, name);
        bus_write(REG_THRESHOLD, bus_data_t'(threshold), 1'b1, name);
        bus_write(REG_UNMAPPED, '1, 1'b0, name);
        if (source == "bus") begin
            bus_write(REG_RUN, 32'd1, 1'b0, name);
        end else if (source == "pin") begin
            gen_enable_in = 1'b1;
        end
        repeat (period + 4) @(posedge clock);
        #1;
        observe_window(name, period, case_cycles[index], exp_pulses, exp_spacing);
        @(posedge clock);
        #1;
    endtask

    initial begin
        int total_cycles;
        reset = 1'b0;
        write_strobe = 1'b0;
        address = '0;
        write_data = '0;
        gen_enable_in = 1'b0;
        error_count = 0;
        load_cases();
        total_cycles = 100;
        foreach (case_names[i]) begin
            total_cycles += case_cycles[i] + case_periods[i] + 40;
        end
        watchdog_cycles = total_cycles;
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b1;
        assert (ready == 1'b1) else begin
            error_count++;
            $display("[FAIL] after_reset ready: expected 1 actual %0b", ready);
        end
        // Period is 0 after reset, so the bypass is active
        observe_window("after_reset", 0, 12, 0, 0);
        @(posedge clock);
        #1;
        foreach (case_names[i]) begin
            run_case(i);
        end
        $display("Cases run: %0d, errors: %0d", case_names.size(), error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: verification/enable_cases.txt
# name period threshold source(bus, pin or none) cycles pulses spacing
# pulses and spacing are 0 where no pulses are expected and for periods 0 and 1
bypass_period_0      0   0  none  16   0   0
bus_p4_t0            4   0  bus   40  10   4
bus_p4_t3            4   3  bus   40  10   4
bus_p7_t2            7   2  bus   42   6   7
bus_p7_t5            7   5  bus   42   6   7
bus_p2_t1            2   1  bus   20  10   2
bus_p2_t0            2   0  bus   20  10   2
bus_p5_t5            5   5  bus   40   0   0
bus_p5_t9            5   9  bus   40   0   0
pin_p6_t1            6   1  pin   36   6   6
pin_p3_t0            3   0  pin   30  10   3
pin_p9_t8            9   8  pin   45   5   9
none_p6_t1           6   1  none  36   0   0
none_p6_t0           6   0  none  36   0   0
bypass_period_1      1   0  bus   24   0   0
bypass_period_1_pin  1   0  pin   24   0   0
bus_p16_t15         16  15  bus   64   4  16
bus_p16_t4          16   4  bus   64   4  16

// File: flist.f
common/bus_pkg.sv
common/timebase_pkg.sv
hdl/bus_register_file.sv
timebase/period_counter.sv
timebase/enable_pulse_shaper.sv
hdl/enable_generator.sv
verification/tb_enable_generator.sv

// File: Makefile
# Verilator build and run for the enable generator testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_enable_generator
FLIST     ?= flist.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --timing --assert -j 0

FAIL_TEXT := STATUS: FAIL
PASS_TEXT := STATUS: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	mkdir -p $(BUILD_DIR)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)/obj
	$(BUILD_DIR)/obj/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
